//--- vlog.f
+incdir+include
source/vshift_pkg.sv
source/vshift_decode.sv
source/vshift_execute.sv
source/vshift_result.sv
source/vshift_unit.sv
tb/vshift_unit_assert.sv
tb/vshift_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the shift unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module vshift_unit_tb -o vshift_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/vshift_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0

//--- tb/vshift_unit_tb.sv
`timescale 1ns/1ns
`include "vshift_cfg.svh"

module vshift_unit_tb;

  import vshift_pkg::*;

  localparam int PERIOD     = 40;
  localparam int DRIVE_DLY  = 5;
  localparam int RST_CYCLES = 2;

  typedef struct {
    string                  name;
    logic                   valid;
    opi_e                   funct3;
    shift_funct_e           funct6;
    eew_e                   eew;
    vxrm_e                  vxrm;
    logic                   idx;
    vreg_t                  vs1;
    vreg_t                  vs2;
    logic [`VSHIFT_XLEN-1:0] rs1;
    logic                   exp_valid;
    vreg_t                  exp_data;
    logic                   exp_sat;
  } row_t;

  logic                    clk;
  logic                    arst_n;
  logic                    uop_valid;
  opi_e                    funct3;
  shift_funct_e            funct6;
  eew_e                    eew;
  vxrm_e                   vxrm;
  logic                    uop_index;
  vreg_t                   vs1_data;
  vreg_t                   vs2_data;
  logic [`VSHIFT_XLEN-1:0] rs1_data;
  logic                    result_valid;
  vreg_t                   result_data;
  logic                    vxsat;

  row_t rows[$];
  int   pass_count;
  int   fail_count;
  logic test_err;

  vshift_unit vshift_unit_inst (
    .clk, .arst_n, .uop_valid, .funct3, .funct6, .eew, .vxrm, .uop_index,
    .vs1_data, .vs2_data, .rs1_data, .result_valid, .result_data, .vxsat
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  task automatic add_row(string name, logic v, opi_e f3, shift_funct_e f6, eew_e ew,
                         vxrm_e rm, logic ix, vreg_t a, vreg_t b,
                         logic [`VSHIFT_XLEN-1:0] s, logic ev, vreg_t ed, logic es);
    row_t r;
    r.name      = name;
    r.valid     = v;
    r.funct3    = f3;
    r.funct6    = f6;
    r.eew       = ew;
    r.vxrm      = rm;
    r.idx       = ix;
    r.vs1       = a;
    r.vs2       = b;
    r.rs1       = s;
    r.exp_valid = ev;
    r.exp_data  = ed;
    r.exp_sat   = es;
    rows.push_back(r);
  endtask

  // expected values worked out by hand per lane
  task automatic build_table();
    add_row("sll16_vv", 1'b1, opivv, vsll, eew16, rnu, 1'b0,
            64'h0013_0008_0001_0004, 64'h1234_00FF_8001_0001, 32'h0,
            1'b1, 64'h91A0_FF00_0002_0010, 1'b0);
    add_row("srl16_vx", 1'b1, opivx, vsrl, eew16, rnu, 1'b0,
            64'hFFFF_FFFF_FFFF_FFFF, 64'hF000_1234_0080_FFFF, 32'h24,
            1'b1, 64'h0F00_0123_0008_0FFF, 1'b0);
    add_row("sra16_vi", 1'b1, opivi, vsra, eew16, rnu, 1'b0,
            64'h0, 64'h8000_7FF0_FFF8_0010, 32'h3,
            1'b1, 64'hF000_0FFE_FFFF_0002, 1'b0);
    add_row("idle_a", 1'b0, opivv, vsll, eew16, rnu, 1'b0,
            64'h0001_0001_0001_0001, 64'hFFFF_FFFF_FFFF_FFFF, 32'h1,
            1'b0, 64'h0, 1'b0);
    add_row("sll32_vx", 1'b1, opivx, vsll, eew32, rnu, 1'b0,
            64'h0, 64'h8000_0001_1234_5678, 32'h21,
            1'b1, 64'h0000_0002_2468_ACF0, 1'b0);
    add_row("srl32_vv", 1'b1, opivv, vsrl, eew32, rnu, 1'b0,
            64'h0000_001F_0000_0008, 64'h8000_0000_1234_5678, 32'h0,
            1'b1, 64'h0000_0001_0012_3456, 1'b0);
    add_row("sra32_vi", 1'b1, opivi, vsra, eew32, rnu, 1'b0,
            64'h0, 64'h8765_4321_7654_3210, 32'h4,
            1'b1, 64'hF876_5432_0765_4321, 1'b0);
    // odd and even kept parts with shifted-out bits above and below half
    add_row("ssrl16_rnu", 1'b1, opivi, vssrl, eew16, rnu, 1'b0,
            64'h0, 64'h0009_0007_000B_0005, 32'h2,
            1'b1, 64'h0002_0002_0003_0001, 1'b0);
    add_row("ssrl16_rne", 1'b1, opivi, vssrl, eew16, rne, 1'b0,
            64'h0, 64'h0009_0007_000B_0005, 32'h2,
            1'b1, 64'h0002_0002_0003_0001, 1'b0);
    add_row("ssrl16_rdn", 1'b1, opivi, vssrl, eew16, rdn, 1'b0,
            64'h0, 64'h0009_0007_000B_0005, 32'h2,
            1'b1, 64'h0002_0001_0002_0001, 1'b0);
    add_row("ssrl16_rod", 1'b1, opivi, vssrl, eew16, rod, 1'b0,
            64'h0, 64'h0009_0007_000B_0005, 32'h2,
            1'b1, 64'h0003_0001_0003_0001, 1'b0);
    // -8 and -24 shifted by 4 give exact ties
    add_row("ssra32_rnu", 1'b1, opivx, vssra, eew32, rnu, 1'b0,
            64'h0, 64'hFFFF_FFE8_FFFF_FFF8, 32'h4,
            1'b1, 64'hFFFF_FFFF_0000_0000, 1'b0);
    add_row("ssra32_rne", 1'b1, opivx, vssra, eew32, rne, 1'b0,
            64'h0, 64'hFFFF_FFE8_FFFF_FFF8, 32'h4,
            1'b1, 64'hFFFF_FFFE_0000_0000, 1'b0);
    add_row("ssra32_rdn", 1'b1, opivx, vssra, eew32, rdn, 1'b0,
            64'h0, 64'hFFFF_FFE8_FFFF_FFF8, 32'h4,
            1'b1, 64'hFFFF_FFFE_FFFF_FFFF, 1'b0);
    add_row("ssra32_rod", 1'b1, opivx, vssra, eew32, rod, 1'b0,
            64'h0, 64'hFFFF_FFE8_FFFF_FFF8, 32'h4,
            1'b1, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
    add_row("idle_clip", 1'b0, opivx, vnclipu, eew16, rnu, 1'b1,
            64'h0, 64'h0FF8_1000_0FF7_0080, 32'h4,
            1'b0, 64'h0, 1'b0);
    add_row("nsrl16_lo", 1'b1, opivi, vnsrl, eew16, rnu, 1'b0,
            64'h0, 64'h1234_ABCD_0FF0_8001, 32'h4,
            1'b1, 64'h0000_0000_23BC_FF00, 1'b0);
    add_row("nsra16_hi", 1'b1, opivx, vnsra, eew16, rnu, 1'b1,
            64'h0, 64'h1234_ABCD_0FF0_8001, 32'hC,
            1'b1, 64'h01FA_00F8_0000_0000, 1'b0);
    add_row("nsrl32_hi", 1'b1, opivv, vnsrl, eew32, rnu, 1'b1,
            64'h0000_0004_0000_0010, 64'h8765_4321_DEAD_BEEF, 32'h0,
            1'b1, 64'h5432_DEAD_0000_0000, 1'b0);
    add_row("nsra32_lo", 1'b1, opivx, vnsra, eew32, rnu, 1'b0,
            64'h0, 64'h8765_4321_DEAD_BEEF, 32'h14,
            1'b1, 64'h0000_0000_F876_FDEA, 1'b0);
    add_row("clipu16_pass", 1'b1, opivi, vnclipu, eew16, rdn, 1'b0,
            64'h0, 64'h0FF0_0120_0010_00FF, 32'h4,
            1'b1, 64'h0000_0000_FF12_010F, 1'b0);
    add_row("clipu16_sat", 1'b1, opivx, vnclipu, eew16, rnu, 1'b1,
            64'h0, 64'h0FF8_1000_0FF7_0080, 32'h4,
            1'b1, 64'hFFFF_FF08_0000_0000, 1'b1);
    add_row("clipu32_sat", 1'b1, opivx, vnclipu, eew32, rdn, 1'b0,
            64'h0, 64'h0010_0000_0000_FFF0, 32'h4,
            1'b1, 64'h0000_0000_FFFF_0FFF, 1'b1);
    add_row("clip32_pass", 1'b1, opivx, vnclip, eew32, rdn, 1'b0,
            64'h0, 64'hFF80_0000_0012_3400, 32'h8,
            1'b1, 64'h0000_0000_8000_1234, 1'b0);
    add_row("clip32_sat", 1'b1, opivx, vnclip, eew32, rnu, 1'b1,
            64'h0, 64'hF000_0000_007F_FF80, 32'h8,
            1'b1, 64'h8000_7FFF_0000_0000, 1'b1);
    add_row("clip16_sat", 1'b1, opivi, vnclip, eew16, rdn, 1'b0,
            64'h0, 64'hFF7F_FF80_0080_007F, 32'h0,
            1'b1, 64'h0000_0000_8080_7F7F, 1'b1);
    add_row("bad_funct6", 1'b1, opivv, shift_funct_e'(6'b000000), eew16, rnu, 1'b0,
            64'h0001_0001_0001_0001, 64'hFFFF_FFFF_FFFF_FFFF, 32'h1,
            1'b0, 64'h0, 1'b0);
    add_row("idle_end", 1'b0, opivv, vsll, eew32, rnu, 1'b0,
            64'h0, 64'h0, 32'h0,
            1'b0, 64'h0, 1'b0);
  endtask

  task automatic drive_row(row_t r);
    uop_valid = r.valid;
    funct3    = r.funct3;
    funct6    = r.funct6;
    eew       = r.eew;
    vxrm      = r.vxrm;
    uop_index = r.idx;
    vs1_data  = r.vs1;
    vs2_data  = r.vs2;
    rs1_data  = r.rs1;
  endtask

  task automatic check_valid(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %s valid: expected %b, actual %b", name, exp, act);
      test_err = 1'b1;
    end
  endtask

  task automatic check_data(string name, vreg_t exp, vreg_t act);
    if (act !== exp) begin
      $display("[ERROR] %s data: expected %h, actual %h", name, exp, act);
      test_err = 1'b1;
    end
  endtask

  task automatic check_sat(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %s vxsat: expected %b, actual %b", name, exp, act);
      test_err = 1'b1;
    end
  endtask

  task automatic run_checks(string name, logic ev, vreg_t ed, logic es);
    test_err = 1'b0;
    check_valid(name, ev, result_valid);
    check_data(name, ed, result_data);
    check_sat(name, es, vxsat);
    if (test_err) begin
      fail_count++;
      $display("[FAIL] %s", name);
    end else begin
      pass_count++;
      $display("[PASS] %s", name);
    end
  endtask

  initial begin
    pass_count = 0;
    fail_count = 0;
    test_err   = 1'b0;
    arst_n     = 1'b0;
    uop_valid  = 1'b0;
    funct3     = opivv;
    funct6     = vsll;
    eew        = eew16;
    vxrm       = rnu;
    uop_index  = 1'b0;
    vs1_data   = '0;
    vs2_data   = '0;
    rs1_data   = '0;
    build_table();
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    run_checks("reset", 1'b0, '0, 1'b0);
    arst_n = 1'b1;
    drive_row(rows[0]);
    // each row is checked one edge after it is driven
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      run_checks(rows[i].name, rows[i].exp_valid, rows[i].exp_data, rows[i].exp_sat);
      if (i + 1 < rows.size())
        drive_row(rows[i+1]);
      else
        uop_valid = 1'b0;
    end
    $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog allows three periods per row plus reset
  initial begin
    #1;
    #((rows.size() * 3 + RST_CYCLES) * PERIOD);
    $display("timeout: the run did not finish in the expected number of clock periods");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tb/vshift_unit_assert.sv
`timescale 1ns/1ns

module vshift_unit_assert (
  input logic                     clk,
  input logic                     arst_n,
  input logic                     uop_valid,
  input vshift_pkg::shift_funct_e funct6,
  input logic                     result_valid,
  input logic                     vxsat
);

  import vshift_pkg::*;

  logic kept_op;

  assign kept_op = funct6 inside {vsll, vsrl, vsra, vssrl, vssra,
                                  vnsrl, vnsra, vnclipu, vnclip};

  reset_clears_valid: assert property (@(posedge clk) !arst_n |-> !result_valid)
    else $error("result_valid high while reset is asserted");

  sat_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
    vxsat |-> result_valid)
    else $error("vxsat high without result_valid");

  // one cycle latency for every accepted micro-op
  valid_follows_uop: assert property (@(posedge clk) disable iff (!arst_n)
    (uop_valid && kept_op) |=> result_valid)
    else $error("result_valid missing one cycle after a valid micro-op");

endmodule

bind vshift_unit vshift_unit_assert assert_inst (.*);

//--- source/vshift_unit.sv
`timescale 1ns/1ns
`include "vshift_cfg.svh"

module vshift_unit (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      uop_valid,
  input  vshift_pkg::opi_e          funct3,
  input  vshift_pkg::shift_funct_e  funct6,
  input  vshift_pkg::eew_e          eew,
  input  vshift_pkg::vxrm_e         vxrm,
  input  logic                      uop_index,
  input  vshift_pkg::vreg_t         vs1_data,
  input  vshift_pkg::vreg_t         vs2_data,
  input  logic [`VSHIFT_XLEN-1:0]   rs1_data,
  output logic                      result_valid,
  output vshift_pkg::vreg_t         result_data,
  output logic                      vxsat
);

  import vshift_pkg::*;

  logic                                                 dec_valid;
  result_kind_e                                         kind;
  shift_op_e                                            shift_op;
  vreg_t                                                src2;
  logic [`VSHIFT_N16-1:0][$clog2(`VSHIFT_HWORD_W)-1:0]  amount16;
  logic [`VSHIFT_N32-1:0][$clog2(`VSHIFT_WORD_W)-1:0]   amount32;
  logic [`VSHIFT_N16-1:0][`VSHIFT_HWORD_W-1:0]          product16;
  logic [`VSHIFT_N32-1:0][`VSHIFT_WORD_W-1:0]           product32;
  logic [`VSHIFT_N16-1:0][`VSHIFT_HWORD_W-1:0]          round16;
  logic [`VSHIFT_N32-1:0][`VSHIFT_WORD_W-1:0]           round32;
  logic [`VSHIFT_N16-1:0]                               cout16;
  logic [`VSHIFT_N32-1:0]                               cout32;

  vshift_decode decode_inst (
    .uop_valid, .funct3, .funct6, .eew, .vs1_data, .vs2_data, .rs1_data,
    .dec_valid, .kind, .shift_op, .src2, .amount16, .amount32
  );

  vshift_execute execute_inst (
    .shift_op, .vxrm, .src2, .amount16, .amount32,
    .product16, .product32, .round16, .round32, .cout16, .cout32
  );

  // registered result stage
  vshift_result result_inst (
    .clk, .arst_n, .dec_valid, .kind, .eew, .uop_index,
    .product16, .product32, .round16, .round32, .cout16, .cout32,
    .result_valid, .result_data, .vxsat
  );

endmodule

//--- source/vshift_result.sv
`timescale 1ns/1ns
`include "vshift_cfg.svh"

module vshift_result (
  input  logic                                         clk,
  input  logic                                         arst_n,
  input  logic                                         dec_valid,
  input  vshift_pkg::result_kind_e                     kind,
  input  vshift_pkg::eew_e                             eew,
  input  logic                                         uop_index,
  input  logic [`VSHIFT_N16-1:0][`VSHIFT_HWORD_W-1:0]  product16,
  input  logic [`VSHIFT_N32-1:0][`VSHIFT_WORD_W-1:0]   product32,
  input  logic [`VSHIFT_N16-1:0][`VSHIFT_HWORD_W-1:0]  round16,
  input  logic [`VSHIFT_N32-1:0][`VSHIFT_WORD_W-1:0]   round32,
  input  logic [`VSHIFT_N16-1:0]                       cout16,
  input  logic [`VSHIFT_N32-1:0]                       cout32,
  output logic                                         result_valid,
  output vshift_pkg::vreg_t                            result_data,
  output logic                                         vxsat
);

  import vshift_pkg::*;

  localparam int BW = `VSHIFT_BYTE_W;
  localparam int HW = `VSHIFT_HWORD_W;
  localparam int HALF = `VSHIFT_VLEN/2;

  logic [`VSHIFT_N16-1:0][BW-1:0] narrow16;
  logic [`VSHIFT_N32-1:0][HW-1:0] narrow32;
  logic [`VSHIFT_N16-1:0]         sat16;
  logic [`VSHIFT_N32-1:0]         sat32;
  logic [HALF-1:0]                half;
  vreg_t                          data_nxt;
  logic                           sat_nxt;

  // 16-bit sources narrow to bytes
  for (genvar i = 0; i < `VSHIFT_N16; i++) begin : g_lane16
    logic [BW:0]   top_u;
    logic [BW+1:0] top_s;
    logic [BW-1:0] lane;
    logic          sat;

    assign top_u = {cout16[i], round16[i][HW-1:BW]};
    assign top_s = {cout16[i], round16[i][HW-1:BW-1]};

    always_comb begin
      lane = product16[i][BW-1:0];
      sat  = 1'b0;
      case (kind)
        kind_clipu: begin
          lane = round16[i][BW-1:0];
          if (|top_u) begin
            lane = '1;
            sat  = 1'b1;
          end
        end
        kind_clip: begin
          lane = round16[i][BW-1:0];
          if (!cout16[i] && (|top_s)) begin
            lane = {1'b0, {(BW-1){1'b1}}};
            sat  = 1'b1;
          end else if (cout16[i] && !(&top_s)) begin
            lane = {1'b1, {(BW-1){1'b0}}};
            sat  = 1'b1;
          end
        end
        default: ;
      endcase
    end

    assign narrow16[i] = lane;
    assign sat16[i]    = sat;
  end

  // 32-bit sources narrow to half words
  for (genvar i = 0; i < `VSHIFT_N32; i++) begin : g_lane32
    logic [HW:0]   top_u;
    logic [HW+1:0] top_s;
    logic [HW-1:0] lane;
    logic          sat;

    assign top_u = {cout32[i], round32[i][2*HW-1:HW]};
    assign top_s = {cout32[i], round32[i][2*HW-1:HW-1]};

    always_comb begin
      lane = product32[i][HW-1:0];
      sat  = 1'b0;
      case (kind)
        kind_clipu: begin
          lane = round32[i][HW-1:0];
          if (|top_u) begin
            lane = '1;
            sat  = 1'b1;
          end
        end
        kind_clip: begin
          lane = round32[i][HW-1:0];
          if (!cout32[i] && (|top_s)) begin
            lane = {1'b0, {(HW-1){1'b1}}};
            sat  = 1'b1;
          end else if (cout32[i] && !(&top_s)) begin
            lane = {1'b1, {(HW-1){1'b0}}};
            sat  = 1'b1;
          end
        end
        default: ;
      endcase
    end

    assign narrow32[i] = lane;
    assign sat32[i]    = sat;
  end

  always_comb begin
    data_nxt = '0;
    sat_nxt  = 1'b0;
    half     = '0;
    case (kind)
      kind_plain: begin
        if (eew == eew16) data_nxt = product16;
        else if (eew == eew32) data_nxt = product32;
      end
      kind_scaled: begin
        if (eew == eew16) data_nxt = round16;
        else if (eew == eew32) data_nxt = round32;
      end
      kind_narrow, kind_clipu, kind_clip: begin
        if (eew == eew16) begin
          half    = narrow16;
          sat_nxt = |sat16;
        end else if (eew == eew32) begin
          half    = narrow32;
          sat_nxt = |sat32;
        end
        // uop_index picks the destination half
        if (uop_index) data_nxt[HALF +: HALF] = half;
        else data_nxt[0 +: HALF] = half;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
      result_data  <= '0;
      vxsat        <= 1'b0;
    end else begin
      result_valid <= dec_valid;
      result_data  <= dec_valid ? data_nxt : '0;
      vxsat        <= dec_valid & sat_nxt;
    end
  end

endmodule

//--- source/vshift_execute.sv
`timescale 1ns/1ns
`include "vshift_cfg.svh"

module vshift_execute (
  input  vshift_pkg::shift_op_e                                 shift_op,
  input  vshift_pkg::vxrm_e                                     vxrm,
  input  vshift_pkg::vreg_t                                     src2,
  input  logic [`VSHIFT_N16-1:0][$clog2(`VSHIFT_HWORD_W)-1:0]   amount16,
  input  logic [`VSHIFT_N32-1:0][$clog2(`VSHIFT_WORD_W)-1:0]    amount32,
  output logic [`VSHIFT_N16-1:0][`VSHIFT_HWORD_W-1:0]           product16,
  output logic [`VSHIFT_N32-1:0][`VSHIFT_WORD_W-1:0]            product32,
  output logic [`VSHIFT_N16-1:0][`VSHIFT_HWORD_W-1:0]           round16,
  output logic [`VSHIFT_N32-1:0][`VSHIFT_WORD_W-1:0]            round32,
  output logic [`VSHIFT_N16-1:0]                                cout16,
  output logic [`VSHIFT_N32-1:0]                                cout32
);

  import vshift_pkg::*;

  localparam int HW = `VSHIFT_HWORD_W;
  localparam int WW = `VSHIFT_WORD_W;

  // rvv fixed-point increment, lsb is the lowest kept bit
  function automatic logic round_inc(vxrm_e mode, logic r_msb, logic r_rest, logic lsb);
    logic inc;
    case (mode)
      rnu:     inc = r_msb;
      rne:     inc = r_msb & (r_rest | lsb);
      rdn:     inc = 1'b0;
      rod:     inc = ~lsb & (r_msb | r_rest);
      default: inc = 1'b0;
    endcase
    return inc;
  endfunction

  for (genvar i = 0; i < `VSHIFT_N16; i++) begin : g_lane16
    logic [2*HW-1:0] wide;
    logic [HW-1:0]   rbits;
    logic            inc;
    logic [HW:0]     sum;

    // low zero field catches the shifted-out bits
    always_comb begin
      case (shift_op)
        shift_sll: wide = {src2[i*HW +: HW], {HW{1'b0}}} << amount16[i];
        shift_srl: wide = {src2[i*HW +: HW], {HW{1'b0}}} >> amount16[i];
        shift_sra: wide = $signed({src2[i*HW +: HW], {HW{1'b0}}}) >>> amount16[i];
        default:   wide = '0;
      endcase
    end

    assign {product16[i], rbits} = wide;
    assign inc = round_inc(vxrm, rbits[HW-1], |rbits[HW-2:0], product16[i][0]);

    always_comb begin
      sum = '0;
      if (shift_op == shift_srl)
        sum = {1'b0, product16[i]} + inc;
      else if (shift_op == shift_sra)
        sum = {product16[i][HW-1], product16[i]} + inc;
    end

    assign {cout16[i], round16[i]} = sum;
  end

  for (genvar i = 0; i < `VSHIFT_N32; i++) begin : g_lane32
    logic [2*WW-1:0] wide;
    logic [WW-1:0]   rbits;
    logic            inc;
    logic [WW:0]     sum;

    always_comb begin
      case (shift_op)
        shift_sll: wide = {src2[i*WW +: WW], {WW{1'b0}}} << amount32[i];
        shift_srl: wide = {src2[i*WW +: WW], {WW{1'b0}}} >> amount32[i];
        shift_sra: wide = $signed({src2[i*WW +: WW], {WW{1'b0}}}) >>> amount32[i];
        default:   wide = '0;
      endcase
    end

    assign {product32[i], rbits} = wide;
    assign inc = round_inc(vxrm, rbits[WW-1], |rbits[WW-2:0], product32[i][0]);

    // sign extend for sra so cout is the true sign
    always_comb begin
      sum = '0;
      if (shift_op == shift_srl)
        sum = {1'b0, product32[i]} + inc;
      else if (shift_op == shift_sra)
        sum = {product32[i][WW-1], product32[i]} + inc;
    end

    assign {cout32[i], round32[i]} = sum;
  end

endmodule

//--- source/vshift_decode.sv
`timescale 1ns/1ns
`include "vshift_cfg.svh"

module vshift_decode (
  input  logic                                                    uop_valid,
  input  vshift_pkg::opi_e                                        funct3,
  input  vshift_pkg::shift_funct_e                                funct6,
  input  vshift_pkg::eew_e                                        eew,
  input  vshift_pkg::vreg_t                                       vs1_data,
  input  vshift_pkg::vreg_t                                       vs2_data,
  input  logic [`VSHIFT_XLEN-1:0]                                 rs1_data,
  output logic                                                    dec_valid,
  output vshift_pkg::result_kind_e                                kind,
  output vshift_pkg::shift_op_e                                   shift_op,
  output vshift_pkg::vreg_t                                       src2,
  output logic [`VSHIFT_N16-1:0][$clog2(`VSHIFT_HWORD_W)-1:0]     amount16,
  output logic [`VSHIFT_N32-1:0][$clog2(`VSHIFT_WORD_W)-1:0]      amount32
);

  import vshift_pkg::*;

  localparam int A16W = $clog2(`VSHIFT_HWORD_W);
  localparam int A32W = $clog2(`VSHIFT_WORD_W);

  logic kept;

  // function to shifter op and result kind
  always_comb begin
    kept     = 1'b1;
    shift_op = shift_sll;
    kind     = kind_plain;
    case (funct6)
      vsll: begin
        shift_op = shift_sll;
      end
      vsrl: shift_op = shift_srl;
      vsra: shift_op = shift_sra;
      vssrl: begin
        shift_op = shift_srl;
        kind     = kind_scaled;
      end
      vssra: begin
        shift_op = shift_sra;
        kind     = kind_scaled;
      end
      vnsrl: begin
        shift_op = shift_srl;
        kind     = kind_narrow;
      end
      vnsra: begin
        shift_op = shift_sra;
        kind     = kind_narrow;
      end
      vnclipu: begin
        shift_op = shift_srl;
        kind     = kind_clipu;
      end
      vnclip: begin
        shift_op = shift_sra;
        kind     = kind_clip;
      end
      default: kept = 1'b0;
    endcase
  end

  assign dec_valid = uop_valid & kept;
  assign src2      = vs2_data;

  // per-lane vs1 amount for opivv, broadcast rs1 otherwise
  always_comb begin
    amount16 = '0;
    amount32 = '0;
    case (eew)
      eew16: begin
        for (int i = 0; i < `VSHIFT_N16; i++) begin
          amount16[i] = (funct3 == opivv) ? vs1_data[i*`VSHIFT_HWORD_W +: A16W]
                                          : rs1_data[A16W-1:0];
        end
      end
      eew32: begin
        for (int i = 0; i < `VSHIFT_N32; i++) begin
          amount32[i] = (funct3 == opivv) ? vs1_data[i*`VSHIFT_WORD_W +: A32W]
                                          : rs1_data[A32W-1:0];
        end
      end
      default: ;
    endcase
  end

endmodule

//--- source/vshift_pkg.sv
`include "vshift_cfg.svh"

package vshift_pkg;

  typedef enum logic [2:0] {
    opivv = 3'b000,
    opivi = 3'b011,
    opivx = 3'b100
  } opi_e;

  // rvv opi funct6 encodings
  typedef enum logic [5:0] {
    vsll    = 6'b100101,
    vsrl    = 6'b101000,
    vsra    = 6'b101001,
    vssrl   = 6'b101010,
    vssra   = 6'b101011,
    vnsrl   = 6'b101100,
    vnsra   = 6'b101101,
    vnclipu = 6'b101110,
    vnclip  = 6'b101111
  } shift_funct_e;

  typedef enum logic [1:0] {eew16 = 2'b01, eew32 = 2'b10} eew_e;

  typedef enum logic [1:0] {rnu = 2'd0, rne = 2'd1, rdn = 2'd2, rod = 2'd3} vxrm_e;

  typedef enum logic [1:0] {shift_sll = 2'd0, shift_srl = 2'd1, shift_sra = 2'd2} shift_op_e;

  typedef enum logic [2:0] {
    kind_plain, kind_scaled, kind_narrow, kind_clipu, kind_clip
  } result_kind_e;

  typedef logic [`VSHIFT_VLEN-1:0] vreg_t;

endpackage

//--- include/vshift_cfg.svh
`ifndef VSHIFT_CFG_SVH
`define VSHIFT_CFG_SVH

// vector register and scalar widths
`define VSHIFT_VLEN 64
`define VSHIFT_XLEN 32

// element widths
`define VSHIFT_BYTE_W  8
`define VSHIFT_HWORD_W 16
`define VSHIFT_WORD_W  32

// lanes per vector register
`define VSHIFT_N16 (`VSHIFT_VLEN/`VSHIFT_HWORD_W)
`define VSHIFT_N32 (`VSHIFT_VLEN/`VSHIFT_WORD_W)

`endif
